// File: design/perf_counter_pkg.sv
package perf_counter_pkg;

  // Counter low halves sit at 0xB00 plus the counter index
  localparam logic [11:0] csr_mcycle           = 12'hB00;
  localparam logic [11:0] csr_minstret         = 12'hB02;
  localparam logic [11:0] csr_mhpmcounter_base = 12'hB03;

  // High halves follow the same index pattern at 0xB80
  localparam logic [11:0] csr_mcycleh          = 12'hB80;

  // Inhibit register and the first event selector
  localparam logic [11:0] csr_mcountinhibit    = 12'h320;
  localparam logic [11:0] csr_mhpmevent_base   = 12'h323;

  // Counter slot numbers
  localparam int idx_cycle     = 0;
  localparam int idx_instret   = 2;
  localparam int idx_hpm_first = 3;

  // Width of the event input vector and of each selector mask
  localparam int num_events = 8;

  // One slot per pattern of the five low address bits
  localparam int max_counters = 32;

endpackage

// File: design/counter_bus_if.sv
`timescale 1ns/1ps

interface counter_bus_if import perf_counter_pkg::*; #(
  parameter int num_hpm = 4
) ();

  // Slots 0 up to the last event counter, slot 1 is the unused time slot
  localparam int num_cnt = idx_hpm_first + num_hpm;

  // Write strobes for the low and high halves
  logic [num_cnt-1:0] we;
  logic [num_cnt-1:0] weh;
  logic [31:0]        wdata;

  // Per-slot count enables
  logic [num_cnt-1:0] inc;

  // Current 64-bit counter values, zero-extended
  logic [63:0]        values [num_cnt];

  modport csr (
    output we, weh, wdata,
    input  values
  );

  modport evt (
    output inc
  );

  modport bank (
    input  we, weh, wdata, inc,
    output values
  );

endinterface

// File: design/perf_counter.sv
`timescale 1ns/1ps

module perf_counter #(
  parameter int counter_width = 64
) (
  input  logic        clk,
  input  logic        rst_n,

  input  logic        inc_i,
  input  logic        we_i,
  input  logic        weh_i,
  input  logic [31:0] wdata_i,
  output logic [63:0] val_o
);

  logic [counter_width-1:0] count_q;
  logic [counter_width-1:0] count_d;
  logic [63:0]              count_ext;
  logic [63:0]              load_val;

  // Merge the written half with the half that is kept
  always_comb begin
    load_val = count_ext;
    if (weh_i) begin
      load_val[63:32] = wdata_i;
    end else begin
      load_val[31:0] = wdata_i;
    end
  end

  // Write beats increment, increment beats hold
  always_comb begin
    if (we_i || weh_i) begin
      count_d = load_val[counter_width-1:0];
    end else if (inc_i) begin
      count_d = count_q + 1'b1;
    end else begin
      count_d = count_q;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count_q <= '0;
    end else begin
      count_q <= count_d;
    end
  end

  // Bits above the implemented width read as zero
  if (counter_width < 64) begin : g_narrow
    assign count_ext = {{(64 - counter_width){1'b0}}, count_q};
  end else begin : g_full
    assign count_ext = count_q;
  end

  assign val_o = count_ext;

  // The CSR decoder only ever selects one half per write
  a_single_half_write : assert property (
    @(posedge clk) disable iff (!rst_n) !(we_i && weh_i)
  ) else $error("perf_counter: low and high half written together");

endmodule

// File: design/perf_event_select.sv
`timescale 1ns/1ps

module perf_event_select import perf_counter_pkg::*; #(
  parameter int num_hpm = 4
) (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  instr_ret_i,
  input  logic [num_events-1:0] event_i,

  input  logic [31:0]           inhibit_i,
  input  logic [num_events-1:0] event_mask_i [num_hpm],

  counter_bus_if.evt            bus
);

  logic                  instr_ret_q;
  logic [num_events-1:0] event_q;

  // Events are counted one cycle after they are sampled
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      instr_ret_q <= 1'b0;
      event_q     <= '0;
    end else begin
      instr_ret_q <= instr_ret_i;
      event_q     <= event_i;
    end
  end

  always_comb begin
    bus.inc = '0;

    // mcycle runs free unless inhibited
    bus.inc[idx_cycle]   = ~inhibit_i[idx_cycle];
    bus.inc[idx_instret] = instr_ret_q & ~inhibit_i[idx_instret];

    // Any selected event counts once, however many are set
    for (int k = 0; k < num_hpm; k++) begin
      bus.inc[idx_hpm_first + k] = (|(event_q & event_mask_i[k]))
                                   & ~inhibit_i[idx_hpm_first + k];
    end
  end

  // Slot 1 has no counter behind it
  a_no_time_inc : assert property (
    @(posedge clk) disable iff (!rst_n) !bus.inc[1]
  ) else $error("perf_event_select: increment raised on time slot");

endmodule

// File: design/perf_csr_file.sv
`timescale 1ns/1ps

module perf_csr_file import perf_counter_pkg::*; #(
  parameter int num_hpm = 4
) (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic [11:0]           csr_addr_i,
  input  logic                  csr_we_i,
  input  logic [31:0]           csr_wdata_i,
  output logic [31:0]           csr_rdata_o,

  output logic [31:0]           inhibit_o,
  output logic [num_events-1:0] event_mask_o [num_hpm],

  counter_bus_if.csr            bus
);

  localparam int num_cnt = idx_hpm_first + num_hpm;

  logic [6:0]              region;
  logic [4:0]              idx;

  logic                    lo_sel;
  logic                    hi_sel;
  logic                    inhibit_sel;
  logic                    event_sel;

  logic [max_counters-1:0] impl_mask;
  logic [num_cnt-1:0]      cnt_hit;
  logic [num_hpm-1:0]      hpm_hit;

  logic [max_counters-1:0] inhibit_q;
  logic [num_events-1:0]   mask_q [num_hpm];

  // Upper bits pick the register group, lower bits the slot
  assign region = csr_addr_i[11:5];
  assign idx    = csr_addr_i[4:0];

  assign lo_sel      = (region == csr_mcycle[11:5]);
  assign hi_sel      = (region == csr_mcycleh[11:5]);
  assign inhibit_sel = (csr_addr_i == csr_mcountinhibit);
  assign event_sel   = (region == csr_mhpmevent_base[11:5]);

  // Slots that have a counter behind them
  for (genvar i = 0; i < max_counters; i++) begin : g_impl
    assign impl_mask[i] = (5'(i) == csr_mcycle[4:0])
                       || (5'(i) == csr_minstret[4:0])
                       || ((5'(i) >= csr_mhpmcounter_base[4:0]) && (i < num_cnt));
  end

  for (genvar i = 0; i < num_cnt; i++) begin : g_cnt_hit
    assign cnt_hit[i] = impl_mask[i] && (idx == 5'(i));
  end

  // Selector k lives at 0x323 plus k
  for (genvar k = 0; k < num_hpm; k++) begin : g_hpm_hit
    assign hpm_hit[k] = (idx == csr_mhpmevent_base[4:0] + 5'(k));
  end

  // Counter write strobes
  always_comb begin
    for (int i = 0; i < num_cnt; i++) begin
      bus.we[i]  = csr_we_i && lo_sel && cnt_hit[i];
      bus.weh[i] = csr_we_i && hi_sel && cnt_hit[i];
    end
  end

  assign bus.wdata = csr_wdata_i;

  // mcountinhibit keeps only implemented bits
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      inhibit_q <= '0;
    end else if (csr_we_i && inhibit_sel) begin
      inhibit_q <= csr_wdata_i & impl_mask;
    end
  end

  // mhpmevent selector masks
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int k = 0; k < num_hpm; k++) begin
        mask_q[k] <= '0;
      end
    end else begin
      for (int k = 0; k < num_hpm; k++) begin
        if (csr_we_i && event_sel && hpm_hit[k]) begin
          mask_q[k] <= csr_wdata_i[num_events-1:0];
        end
      end
    end
  end

  assign inhibit_o    = inhibit_q;
  assign event_mask_o = mask_q;

  // Read mux, anything unmatched returns zero
  always_comb begin
    csr_rdata_o = '0;
    if (inhibit_sel) begin
      csr_rdata_o = inhibit_q;
    end
    for (int k = 0; k < num_hpm; k++) begin
      if (event_sel && hpm_hit[k]) begin
        csr_rdata_o = {{(32 - num_events){1'b0}}, mask_q[k]};
      end
    end
    for (int i = 0; i < num_cnt; i++) begin
      if (cnt_hit[i] && lo_sel) begin
        csr_rdata_o = bus.values[i][31:0];
      end
      if (cnt_hit[i] && hi_sel) begin
        csr_rdata_o = bus.values[i][63:32];
      end
    end
  end

  // One CSR write touches at most one counter half
  a_one_strobe : assert property (
    @(posedge clk) disable iff (!rst_n) $onehot0({bus.we, bus.weh})
  ) else $error("perf_csr_file: more than one counter write strobe");

endmodule

// File: design/perf_counter_unit.sv
`timescale 1ns/1ps

module perf_counter_unit import perf_counter_pkg::*; #(
  parameter int num_hpm   = 4,
  parameter int hpm_width = 40
) (
  input  logic                  clk,
  input  logic                  rst_n,

  // CSR access
  input  logic [11:0]           csr_addr_i,
  input  logic                  csr_we_i,
  input  logic [31:0]           csr_wdata_i,
  output logic [31:0]           csr_rdata_o,

  // Event sources
  input  logic                  instr_ret_i,
  input  logic [num_events-1:0] event_i
);

  localparam int num_cnt = idx_hpm_first + num_hpm;

  logic [31:0]           inhibit;
  logic [num_events-1:0] event_mask [num_hpm];

  counter_bus_if #(.num_hpm(num_hpm)) cnt_bus ();

  perf_csr_file #(
    .num_hpm      (num_hpm)
  ) u_csr_file (
    .clk          (clk),
    .rst_n        (rst_n),
    .csr_addr_i   (csr_addr_i),
    .csr_we_i     (csr_we_i),
    .csr_wdata_i  (csr_wdata_i),
    .csr_rdata_o  (csr_rdata_o),
    .inhibit_o    (inhibit),
    .event_mask_o (event_mask),
    .bus          (cnt_bus.csr)
  );

  perf_event_select #(
    .num_hpm      (num_hpm)
  ) u_event_select (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_ret_i  (instr_ret_i),
    .event_i      (event_i),
    .inhibit_i    (inhibit),
    .event_mask_i (event_mask),
    .bus          (cnt_bus.evt)
  );

  // Counter bank, mcycle and minstret are full width
  for (genvar i = 0; i < num_cnt; i++) begin : g_cnt
    if (i == 1) begin : g_time
      // time is not kept here
      assign cnt_bus.values[i] = '0;
    end else begin : g_counter
      perf_counter #(
        .counter_width (i < idx_hpm_first ? 64 : hpm_width)
      ) u_counter (
        .clk           (clk),
        .rst_n         (rst_n),
        .inc_i         (cnt_bus.inc[i]),
        .we_i          (cnt_bus.we[i]),
        .weh_i         (cnt_bus.weh[i]),
        .wdata_i       (cnt_bus.wdata),
        .val_o         (cnt_bus.values[i])
      );
    end
  end

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter real period_ns = 4.0
) (
  output logic clk_o
);

  // Free-running clock, starts low
  initial begin
    clk_o = 1'b0;
    forever begin
      #(period_ns / 2.0);
      clk_o = ~clk_o;
    end
  end

endmodule

// File: bench/tb_perf_counter_unit.sv
`timescale 1ns/1ps

module tb_perf_counter_unit
  import perf_counter_pkg::*;
();

  localparam int num_hpm    = 4;
  localparam int hpm_width  = 40;
  localparam int num_cnt    = idx_hpm_first + num_hpm;
  localparam int mix_cycles = 3000;

  // Addresses with nothing behind them
  localparam logic [11:0] unimpl_addr [10] = '{
    12'hB01, 12'hB81, 12'hB07, 12'hB1F, 12'hB9F,
    12'h321, 12'h322, 12'h327, 12'h000, 12'hC00
  };

  logic                  clk;
  logic                  rst_n;
  logic [11:0]           csr_addr_i;
  logic                  csr_we_i;
  logic [31:0]           csr_wdata_i;
  logic [31:0]           csr_rdata_o;
  logic                  instr_ret_i;
  logic [num_events-1:0] event_i;

  // Inputs held during the current cycle, sampled at the next edge
  logic                  d_rst;
  logic [11:0]           d_addr;
  logic                  d_we;
  logic [31:0]           d_wdata;
  logic                  d_ir;
  logic [num_events-1:0] d_ev;

  // Reference model state
  logic [63:0]           m_cnt [num_cnt];
  logic [31:0]           m_inhibit;
  logic [num_events-1:0] m_mask [num_hpm];
  logic                  m_ir_q;
  logic [num_events-1:0] m_ev_q;

  logic [31:0]           rng_state;
  int                    errors;
  int                    checks;

  tb_clock #(.period_ns(4.0)) u_clock (.clk_o(clk));

  perf_counter_unit UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .csr_addr_i  (csr_addr_i),
    .csr_we_i    (csr_we_i),
    .csr_wdata_i (csr_wdata_i),
    .csr_rdata_o (csr_rdata_o),
    .instr_ret_i (instr_ret_i),
    .event_i     (event_i)
  );

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic bit slot_impl(input int k);
    return (k == idx_cycle) || (k == idx_instret) || (k >= idx_hpm_first && k < num_cnt);
  endfunction

  function automatic logic [63:0] width_mask(input int k);
    if (k < idx_hpm_first) begin
      return '1;
    end
    return (64'd1 << hpm_width) - 64'd1;
  endfunction

  function automatic logic [31:0] impl_bits();
    logic [31:0] b;
    b = '0;
    for (int k = 0; k < 32; k++) begin
      b[k] = slot_impl(k);
    end
    return b;
  endfunction

  // Expected read data for an address
  function automatic logic [31:0] model_read(input logic [11:0] a);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < num_cnt; k++) begin
      if (slot_impl(k) && a == csr_mcycle + 12'(k)) r = m_cnt[k][31:0];
      if (slot_impl(k) && a == csr_mcycleh + 12'(k)) r = m_cnt[k][63:32];
    end
    if (a == csr_mcountinhibit) r = m_inhibit;
    for (int k = 0; k < num_hpm; k++) begin
      if (a == csr_mhpmevent_base + 12'(k)) r = {{(32 - num_events){1'b0}}, m_mask[k]};
    end
    return r;
  endfunction

  // Advance the model by one clock edge
  task automatic model_edge();
    logic [num_cnt-1:0] inc;
    logic [63:0]        nv;
    if (!d_rst) begin
      for (int k = 0; k < num_cnt; k++) m_cnt[k] = '0;
      for (int k = 0; k < num_hpm; k++) m_mask[k] = '0;
      m_inhibit = '0;
      m_ir_q    = 1'b0;
      m_ev_q    = '0;
    end else begin
      // Counts use the event register and inhibit from before the edge
      inc = '0;
      inc[idx_cycle]   = !m_inhibit[idx_cycle];
      inc[idx_instret] = m_ir_q && !m_inhibit[idx_instret];
      for (int k = 0; k < num_hpm; k++) begin
        inc[idx_hpm_first + k] = ((m_ev_q & m_mask[k]) != '0)
                                 && !m_inhibit[idx_hpm_first + k];
      end
      for (int k = 0; k < num_cnt; k++) begin
        nv = m_cnt[k];
        if (d_we && d_addr == csr_mcycle + 12'(k)) begin
          nv[31:0] = d_wdata;
        end else if (d_we && d_addr == csr_mcycleh + 12'(k)) begin
          nv[63:32] = d_wdata;
        end else if (inc[k]) begin
          nv = nv + 64'd1;
        end
        m_cnt[k] = slot_impl(k) ? (nv & width_mask(k)) : 64'd0;
      end
      if (d_we && d_addr == csr_mcountinhibit) m_inhibit = d_wdata & impl_bits();
      for (int k = 0; k < num_hpm; k++) begin
        if (d_we && d_addr == csr_mhpmevent_base + 12'(k)) m_mask[k] = d_wdata[num_events-1:0];
      end
      m_ir_q = d_ir;
      m_ev_q = d_ev;
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: time %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Drive at the rising edge and check at the falling edge
  task automatic run_cycle(input logic [11:0] addr, input logic we, input logic [31:0] wdata,
                           input logic ir, input logic [num_events-1:0] ev);
    @(posedge clk);
    model_edge();
    csr_addr_i  <= addr;
    csr_we_i    <= we;
    csr_wdata_i <= wdata;
    instr_ret_i <= ir;
    event_i     <= ev;
    d_addr  = addr;
    d_we    = we;
    d_wdata = wdata;
    d_ir    = ir;
    d_ev    = ev;
    @(negedge clk);
    check_value($sformatf("csr_rdata_o[%03h]", addr), csr_rdata_o, model_read(addr));
  endtask

  task automatic sweep_all();
    run_cycle(csr_mcountinhibit, 1'b0, 32'd0, 1'b0, '0);
    for (int k = 0; k < num_cnt; k++) begin
      run_cycle(csr_mcycle + 12'(k), 1'b0, 32'd0, 1'b0, '0);
      run_cycle(csr_mcycleh + 12'(k), 1'b0, 32'd0, 1'b0, '0);
    end
    for (int k = 0; k < num_hpm; k++) begin
      run_cycle(csr_mhpmevent_base + 12'(k), 1'b0, 32'd0, 1'b0, '0);
    end
  endtask

  // Read mcycle until it reaches target with one count per cycle
  task automatic wait_mcycle(input logic [31:0] target, input int limit);
    logic [31:0] prev;
    int          n;
    run_cycle(csr_mcycle, 1'b0, 32'd0, 1'b0, '0);
    prev = m_cnt[idx_cycle][31:0];
    n    = 0;
    while (csr_rdata_o < target && n < limit) begin
      run_cycle(csr_mcycle, 1'b0, 32'd0, 1'b0, '0);
      check_value("csr_rdata_o mcycle step", csr_rdata_o, prev + 32'd1);
      prev = m_cnt[idx_cycle][31:0];
      n++;
    end
    if (csr_rdata_o < target) begin
      errors++;
      $display("Timeout: mcycle did not reach %0d within %0d cycles", target, limit);
    end
  endtask

  task automatic run_random_events(input int n);
    logic [31:0] r;
    logic [31:0] s;
    logic [11:0] a;
    for (int i = 0; i < n; i++) begin
      r = lcg_next();
      s = lcg_next();
      a = (r[31] ? csr_mcycleh : csr_mcycle) + {9'd0, r[18:16]};
      run_cycle(a, 1'b0, 32'd0, r[30], s[31:24] & s[23:16]);
    end
  endtask

  function automatic logic [11:0] rand_addr();
    logic [31:0] r;
    r = lcg_next();
    case (r[31:29])
      3'd0, 3'd1: return csr_mcycle | {7'd0, r[20:16]};
      3'd2, 3'd3: return csr_mcycleh | {7'd0, r[20:16]};
      3'd4:       return csr_mcountinhibit | {7'd0, r[20:16]};
      3'd5:       return csr_mcountinhibit;
      3'd6:       return csr_mhpmevent_base + {10'd0, r[17:16]};
      default:    return r[27:16];
    endcase
  endfunction

  task automatic run_mix(input int n);
    logic [31:0] r;
    logic [31:0] s;
    logic [31:0] wd;
    logic        we_now;
    logic        we_last;
    we_last = 1'b0;
    for (int i = 0; i < n; i++) begin
      r = lcg_next();
      s = lcg_next();
      we_now = (r[31:30] == 2'b00) && !we_last;
      // Values near all ones push the counters across their wrap points
      wd = r[29] ? s : {28'hFFF_FFFF, s[3:0]};
      run_cycle(rand_addr(), we_now, wd, r[28], s[31:24] & s[23:16]);
      we_last = we_now;
    end
  endtask

  initial begin
    logic [31:0] held;
    rng_state    = 32'h9f3c934f;
    errors       = 0;
    checks       = 0;
    rst_n       <= 1'b0;
    csr_addr_i  <= '0;
    csr_we_i    <= 1'b0;
    csr_wdata_i <= '0;
    instr_ret_i <= 1'b0;
    event_i     <= '0;
    d_rst   = 1'b0;
    d_addr  = '0;
    d_we    = 1'b0;
    d_wdata = '0;
    d_ir    = 1'b0;
    d_ev    = '0;
    model_edge();
    repeat (3) begin
      @(posedge clk);
      model_edge();
    end
    rst_n <= 1'b1;
    d_rst = 1'b1;

    // Reset values, free-running mcycle, unknown addresses
    sweep_all();
    wait_mcycle(32'd40, 100);
    foreach (unimpl_addr[i]) begin
      run_cycle(unimpl_addr[i], 1'b1, lcg_next(), 1'b0, '0);
      run_cycle(unimpl_addr[i], 1'b0, 32'd0, 1'b0, '0);
    end
    sweep_all();

    // Half writes where the mcycle write lands on its own increment
    run_cycle(csr_mcycle, 1'b1, 32'h1234_5678, 1'b0, '0);
    run_cycle(csr_mcycleh, 1'b0, 32'd0, 1'b0, '0);
    run_cycle(csr_mcycleh, 1'b1, 32'hDEAD_BEEF, 1'b0, '0);
    run_cycle(csr_mcycle, 1'b0, 32'd0, 1'b0, '0);
    // Retired instruction would count on the same edge as the write
    run_cycle(csr_minstret, 1'b0, 32'd0, 1'b1, '0);
    run_cycle(csr_minstret, 1'b1, 32'hAAAA_5555, 1'b0, '0);
    run_cycle(csr_minstret, 1'b0, 32'd0, 1'b0, '0);
    run_cycle(csr_mcycleh + 12'(idx_instret), 1'b1, 32'h0000_0001, 1'b1, '0);
    run_cycle(csr_mcycleh + 12'(idx_instret), 1'b0, 32'd0, 1'b0, '0);
    run_cycle(csr_minstret, 1'b0, 32'd0, 1'b0, '0);
    // First event counter on event bit 0 with the high half truncated to 40 bits
    run_cycle(csr_mhpmevent_base, 1'b1, 32'h0000_0001, 1'b0, '0);
    run_cycle(csr_mhpmcounter_base, 1'b0, 32'd0, 1'b0, 8'h01);
    run_cycle(csr_mcycleh + 12'(idx_hpm_first), 1'b1, 32'hFFFF_FFFF, 1'b0, '0);
    run_cycle(csr_mcycleh + 12'(idx_hpm_first), 1'b0, 32'd0, 1'b0, '0);
    check_value("csr_rdata_o mhpmcounter3h", csr_rdata_o, 32'h0000_00FF);
    run_cycle(csr_mhpmcounter_base, 1'b1, 32'hFFFF_FFFE, 1'b0, 8'h01);
    repeat (4) run_cycle(csr_mhpmcounter_base, 1'b0, 32'd0, 1'b0, 8'h01);
    run_cycle(csr_mcycleh + 12'(idx_hpm_first), 1'b0, 32'd0, 1'b0, '0);
    run_cycle(csr_mhpmcounter_base, 1'b0, 32'd0, 1'b0, '0);
    // Several selected events in one cycle count once
    run_cycle(csr_mhpmevent_base, 1'b1, 32'h0000_000F, 1'b0, '0);
    run_cycle(csr_mhpmcounter_base, 1'b0, 32'd0, 1'b0, 8'h0F);
    repeat (2) run_cycle(csr_mhpmcounter_base, 1'b0, 32'd0, 1'b0, '0);

    // Random selectors and events
    for (int k = 0; k < num_hpm; k++) begin
      run_cycle(csr_mhpmevent_base + 12'(k), 1'b1, lcg_next(), 1'b0, '0);
    end
    run_random_events(400);
    sweep_all();

    // Inhibit freezes only the matching counters
    for (int k = 0; k < num_hpm; k++) begin
      run_cycle(csr_mhpmevent_base + 12'(k), 1'b1, 32'h0000_00FF, 1'b0, '0);
    end
    run_cycle(csr_mcountinhibit, 1'b1, 32'hFFFF_FFFF, 1'b0, '0);
    run_cycle(csr_mcountinhibit, 1'b0, 32'd0, 1'b0, '0);
    check_value("csr_rdata_o mcountinhibit", csr_rdata_o, 32'h0000_007D);
    run_cycle(csr_mcycle, 1'b0, 32'd0, 1'b0, '0);
    held = m_cnt[idx_cycle][31:0];
    run_random_events(40);
    run_cycle(csr_mcycle, 1'b0, 32'd0, 1'b0, '0);
    check_value("csr_rdata_o mcycle inhibited", csr_rdata_o, held);
    sweep_all();
    repeat (3) begin
      run_cycle(csr_mcountinhibit, 1'b1, lcg_next(), 1'b0, '0);
      run_random_events(60);
      sweep_all();
    end
    run_cycle(csr_mcountinhibit, 1'b1, 32'd0, 1'b0, '0);
    run_random_events(40);
    sweep_all();

    // Long random mix of writes, reads and events
    run_mix(mix_cycles);
    sweep_all();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: all.f
design/perf_counter_pkg.sv
design/counter_bus_if.sv
design/perf_counter.sv
design/perf_event_select.sv
design/perf_csr_file.sv
design/perf_counter_unit.sv
bench/tb_clock.sv
bench/tb_perf_counter_unit.sv

// File: run.sh
#!/bin/sh
# Build and run the performance counter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f \
  --top-module tb_perf_counter_unit -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_perf_counter_unit 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "All tests passed"; then
  exit 0
fi
exit 1
